// ==== verilog/rvPkg.sv ====
package rvPkg;

    localparam int xlen    = 32;
    localparam int regBits = 5;

    typedef logic [regBits-1:0] regAddr;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        aluPassB = 4'd10    // Used by lui
    } aluOp;

    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2   // Link value of jal/jalr
    } resultSel;

    // Branch conditions as encoded in funct3
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    typedef struct packed {
        logic            jump;
        logic            branch;
        logic            regWrite;
        resultSel        resultSrc;
        logic            memWrite;
        aluOp            aluCtrl;
        logic            aluSrcA;   // 1 selects pc
        logic            aluSrcB;   // 1 selects immediate
        logic [xlen-1:0] rs1Val;
        logic [xlen-1:0] rs2Val;
        logic [xlen-1:0] immExt;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pcPlus4;
        logic [2:0]      funct3;
        regAddr          rs1;
        regAddr          rs2;
        regAddr          rd;
    } decodeBundle;

    typedef struct packed {
        logic            regWrite;
        resultSel        resultSrc;
        logic            memWrite;
        logic [xlen-1:0] aluOut;
        logic [xlen-1:0] rs2Val;    // Store data
        logic [2:0]      funct3;
        regAddr          rd;
        logic [xlen-1:0] pcPlus4;
    } memBundle;

    typedef struct packed {
        logic            regWrite;
        regAddr          rd;
        logic [xlen-1:0] result;
    } wbBundle;

endpackage

// ==== verilog/comparator.sv ====
`timescale 1ns/1ps

module comparator import rvPkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  logic [2:0]      funct3,
    output logic            relation
);

    logic isEqual;
    logic isLess;
    logic isLessU;

    assign isEqual = (a == b);
    assign isLess  = ($signed(a) < $signed(b));
    assign isLessU = (a < b);

    always_comb begin
        case (funct3)
            f3Beq: begin
                relation = isEqual;
            end
            f3Bne: begin
                relation = !isEqual;
            end
            f3Blt: begin
                relation = isLess;
            end
            f3Bge: begin
                relation = !isLess;
            end
            f3Bltu: begin
                relation = isLessU;
            end
            f3Bgeu: begin
                relation = !isLessU;
            end
            default: relation = 1'b0;   // 010 and 011 are not branches
        endcase
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu import rvPkg::*; (
    input  logic [xlen-1:0] opA,
    input  logic [xlen-1:0] opB,
    input  aluOp            op,
    output logic [xlen-1:0] result
);

    logic [4:0] shamt;

    assign shamt = opB[4:0];

    always_comb begin
        case (op)
            aluAdd: begin
                result = opA + opB;
            end
            aluSub: begin
                result = opA - opB;
            end
            aluSll: begin
                result = opA << shamt;
            end
            aluSlt: begin
                result = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
            end
            aluSltu: begin
                result = {{(xlen-1){1'b0}}, opA < opB};
            end
            aluXor: begin
                result = opA ^ opB;
            end
            aluSrl: begin
                result = opA >> shamt;
            end
            aluSra: begin
                result = $unsigned($signed(opA) >>> shamt);   // Sign fill
            end
            aluOr: begin
                result = opA | opB;
            end
            aluAnd: begin
                result = opA & opB;
            end
            aluPassB: begin
                result = opB;
            end
            default: result = '0;
        endcase
    end

endmodule

// ==== verilog/forwardUnit.sv ====
`timescale 1ns/1ps

module forwardUnit import rvPkg::*; (
    input  regAddr          exRs1,
    input  regAddr          exRs2,
    input  logic [xlen-1:0] rs1Val,
    input  logic [xlen-1:0] rs2Val,
    input  memBundle        mem,
    input  wbBundle         wb,
    output logic [xlen-1:0] srcA,
    output logic [xlen-1:0] srcB
);

    // Newest producer wins, x0 stays zero
    function automatic logic [xlen-1:0] pickSource(
        input regAddr          rs,
        input logic [xlen-1:0] regVal,
        input memBundle        memIn,
        input wbBundle         wbIn
    );
        logic memHit;
        logic wbHit;
        memHit = memIn.regWrite && (memIn.rd != '0) && (memIn.rd == rs);
        wbHit  = wbIn.regWrite && (wbIn.rd != '0) && (wbIn.rd == rs);
        if (memHit) begin
            return memIn.aluOut;
        end else if (wbHit) begin
            return wbIn.result;
        end
        return regVal;
    endfunction

    always_comb begin
        srcA = pickSource(exRs1, rs1Val, mem, wb);
        srcB = pickSource(exRs2, rs2Val, mem, wb);
    end

endmodule

// ==== verilog/idExReg.sv ====
`timescale 1ns/1ps

module idExReg import rvPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        flush,
    input  decodeBundle decode,
    output decodeBundle exBundle
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exBundle <= '0;
        end else begin
            exBundle <= decode;
            if (flush) begin
                exBundle.jump      <= 1'b0;    // Squash wrong-path instruction
                exBundle.branch    <= 1'b0;
                exBundle.regWrite  <= 1'b0;
                exBundle.resultSrc <= resAlu;
                exBundle.memWrite  <= 1'b0;
                exBundle.aluCtrl   <= aluAdd;
                exBundle.aluSrcA   <= 1'b0;
                exBundle.aluSrcB   <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/execute.sv ====
`timescale 1ns/1ps

module execute import rvPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  decodeBundle     exBundle,
    input  logic [xlen-1:0] srcA,
    input  logic [xlen-1:0] srcB,
    output memBundle        mem,
    output logic            pcSrc,
    output logic [xlen-1:0] pcTarget
);

    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;
    logic [xlen-1:0] aluResult;
    logic            relation;

    assign opA = exBundle.aluSrcA ? exBundle.pc : srcA;
    assign opB = exBundle.aluSrcB ? exBundle.immExt : srcB;

    comparator branchCmp (
        .a          (srcA),
        .b          (srcB),
        .funct3     (exBundle.funct3),
        .relation   (relation)
    );

    alu aluUnit (
        .opA        (opA),
        .opB        (opB),
        .op         (exBundle.aluCtrl),
        .result     (aluResult)
    );

    // Bubbles carry no branch or jump, so they never redirect
    assign pcSrc    = (exBundle.branch & relation) | exBundle.jump;
    assign pcTarget = aluResult;    // pc+imm, or rs1+imm for jalr

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mem <= '0;
        end else begin
            mem.regWrite  <= exBundle.regWrite;
            mem.resultSrc <= exBundle.resultSrc;
            mem.memWrite  <= exBundle.memWrite;
            mem.aluOut    <= aluResult;
            mem.rs2Val    <= srcB;         // Forwarded store data
            mem.funct3    <= exBundle.funct3;
            mem.rd        <= exBundle.rd;
            mem.pcPlus4   <= exBundle.pcPlus4;
        end
    end

endmodule

// ==== verilog/executeStage.sv ====
`timescale 1ns/1ps

module executeStage import rvPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  decodeBundle     decode,
    input  wbBundle         wb,
    output memBundle        mem,
    output logic            pcSrc,
    output logic [xlen-1:0] pcTarget
);

    decodeBundle     exBundle;
    logic [xlen-1:0] srcA;
    logic [xlen-1:0] srcB;

    // Taken branch or jump kills the instruction behind it
    idExReg idEx (
        .clk        (clk),
        .rstN       (rstN),
        .flush      (pcSrc),
        .decode     (decode),
        .exBundle   (exBundle)
    );

    forwardUnit fwd (
        .exRs1      (exBundle.rs1),
        .exRs2      (exBundle.rs2),
        .rs1Val     (exBundle.rs1Val),
        .rs2Val     (exBundle.rs2Val),
        .mem        (mem),
        .wb         (wb),
        .srcA       (srcA),
        .srcB       (srcB)
    );

    execute exec (
        .clk        (clk),
        .rstN       (rstN),
        .exBundle   (exBundle),
        .srcA       (srcA),
        .srcB       (srcB),
        .mem        (mem),
        .pcSrc      (pcSrc),
        .pcTarget   (pcTarget)
    );

endmodule

// ==== sim/execModel.svh ====
logic [31:0]     rngState = 32'hc036_adc9;
decodeBundle     modelEx;       // Instruction the DUT holds in EX
memBundle        modelMem;      // Expected EX/MEM register contents
memBundle        expMem;        // EX/MEM value after the next edge
logic            expPcSrc;
logic [xlen-1:0] expPcTarget;

function automatic logic [31:0] nextRand();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
endfunction

function automatic int randRange(int n);
    return int'(nextRand() >> 16) % n;   // Low LCG bits have short periods
endfunction

function automatic logic [xlen-1:0] refAlu(aluOp op, logic [xlen-1:0] a, logic [xlen-1:0] b);
    logic [2*xlen-1:0] ext;
    logic              ltu;
    ext = {{xlen{a[xlen-1]}}, a} >> b[4:0];
    ltu = (a < b);
    case (op)
        aluAdd:   return a + b;
        aluSub:   return a + ~b + 32'd1;
        aluSll:   return a << b[4:0];
        aluSlt:   return {31'b0, (a[31] != b[31]) ? a[31] : ltu};
        aluSltu:  return {31'b0, ltu};
        aluXor:   return a ^ b;
        aluSrl:   return a >> b[4:0];
        aluSra:   return ext[xlen-1:0];
        aluOr:    return a | b;
        aluAnd:   return a & b;
        aluPassB: return b;
        default:  return '0;
    endcase
endfunction

function automatic logic refRelation(logic [2:0] f3, logic [xlen-1:0] a, logic [xlen-1:0] b);
    logic ltu;
    logic lt;
    ltu = (a < b);
    lt  = (a[31] != b[31]) ? a[31] : ltu;   // Signs differ, negative one is smaller
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return lt;
        3'b101:  return !lt;
        3'b110:  return ltu;
        3'b111:  return !ltu;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [xlen-1:0] fwdOperand(regAddr rs, logic [xlen-1:0] regVal,
                                               memBundle m, wbBundle w);
    if (m.regWrite && m.rd != 5'd0 && m.rd == rs) begin
        return m.aluOut;
    end
    if (w.regWrite && w.rd != 5'd0 && w.rd == rs) begin
        return w.result;
    end
    return regVal;
endfunction

function automatic decodeBundle squashControls(decodeBundle d);
    d.jump      = 1'b0;
    d.branch    = 1'b0;
    d.regWrite  = 1'b0;
    d.resultSrc = resAlu;
    d.memWrite  = 1'b0;
    d.aluCtrl   = aluAdd;
    d.aluSrcA   = 1'b0;
    d.aluSrcB   = 1'b0;
    return d;
endfunction

task evalModel(input wbBundle w);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] result;
    a      = fwdOperand(modelEx.rs1, modelEx.rs1Val, modelMem, w);
    b      = fwdOperand(modelEx.rs2, modelEx.rs2Val, modelMem, w);
    result = refAlu(modelEx.aluCtrl, modelEx.aluSrcA ? modelEx.pc : a,
                    modelEx.aluSrcB ? modelEx.immExt : b);
    expPcSrc         = (modelEx.branch && refRelation(modelEx.funct3, a, b)) || modelEx.jump;
    expPcTarget      = result;
    expMem.regWrite  = modelEx.regWrite;
    expMem.resultSrc = modelEx.resultSrc;
    expMem.memWrite  = modelEx.memWrite;
    expMem.aluOut    = result;
    expMem.rs2Val    = b;
    expMem.funct3    = modelEx.funct3;
    expMem.rd        = modelEx.rd;
    expMem.pcPlus4   = modelEx.pcPlus4;
endtask

task advanceModel(input decodeBundle d);
    modelMem = expMem;
    if (expPcSrc) begin
        modelEx = squashControls(d);   // Wrong-path instruction
    end else begin
        modelEx = d;
    end
endtask

// ==== sim/tbExecuteStage.sv ====
`timescale 1ns/1ps

module tbExecuteStage import rvPkg::*; ();

    localparam int resetCycles = 3;
    localparam int bubbleCount = 10;
    localparam int aluCount    = 400;
    localparam int fwdCount    = 300;
    localparam int branchCount = 300;
    localparam int flushReps   = 40;
    localparam int storeCount  = 200;
    localparam int drainCount  = 4;
    localparam int cycleLimit  = resetCycles + bubbleCount + aluCount + fwdCount
                                 + branchCount + 4 * flushReps + storeCount + drainCount + 20;

    logic            clk;
    logic            rstN;
    decodeBundle     decode;
    wbBundle         wb;
    memBundle        mem;
    logic            pcSrc;
    logic [xlen-1:0] pcTarget;

    int testChecks;
    int testErrors;
    int totalChecks;
    int totalErrors;
    int testCount;
    int cycleCount;

    `include "execModel.svh"

    executeStage uut (
        .clk      (clk),
        .rstN     (rstN),
        .decode   (decode),
        .wb       (wb),
        .mem      (mem),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget)
    );

    always #20 clk = ~clk;

    function automatic decodeBundle randFields(int srcLo, int rdLo, int span);
        decodeBundle d;
        logic [31:0] pcRaw;
        d         = '0;
        pcRaw     = nextRand();
        d.rs1Val  = nextRand();
        d.rs2Val  = nextRand();
        d.immExt  = nextRand();
        d.pc      = {pcRaw[31:2], 2'b00};
        d.pcPlus4 = d.pc + 32'd4;
        d.funct3  = 3'(randRange(8));
        d.rs1     = regAddr'(srcLo + randRange(span));
        d.rs2     = regAddr'(srcLo + randRange(span));
        d.rd      = regAddr'(rdLo + randRange(span));
        return d;
    endfunction

    function automatic decodeBundle makeAlu(int srcLo, int rdLo, int span);
        decodeBundle d;
        d          = randFields(srcLo, rdLo, span);
        d.regWrite = 1'b1;
        d.aluCtrl  = aluOp'(randRange(11));
        d.aluSrcA  = (randRange(4) == 0);   // auipc style
        d.aluSrcB  = (randRange(2) == 0);
        return d;
    endfunction

    function automatic decodeBundle makeStore();
        decodeBundle d;
        d          = randFields(0, 0, 4);
        d.memWrite = 1'b1;
        d.aluSrcB  = 1'b1;
        d.funct3   = 3'(randRange(3));      // sb, sh, sw
        return d;
    endfunction

    function automatic decodeBundle makeJump(logic viaReg);
        decodeBundle d;
        d           = randFields(0, 0, 4);
        d.jump      = 1'b1;
        d.regWrite  = 1'b1;
        d.resultSrc = resPcPlus4;
        d.aluSrcA   = !viaReg;              // jalr adds to rs1
        d.aluSrcB   = 1'b1;
        return d;
    endfunction

    function automatic decodeBundle randMix();
        decodeBundle d;
        int          kind;
        kind = randRange(8);
        if (kind < 4) begin
            d = makeAlu(0, 0, 4);
        end else if (kind < 6) begin
            d         = randFields(0, 0, 4);
            d.branch  = 1'b1;
            d.aluSrcA = 1'b1;
            d.aluSrcB = 1'b1;
        end else begin
            d = makeJump(kind == 7);
        end
        return d;
    endfunction

    function automatic wbBundle randWb();
        wbBundle w;
        w.regWrite = (randRange(4) != 0);
        w.rd       = regAddr'(randRange(4));
        w.result   = nextRand();
        return w;
    endfunction

    task checkOutputs();
        testChecks++;
        assert (pcSrc === expPcSrc) else begin
            $display("FAIL %0t: pcSrc %b, expected %b", $time, pcSrc, expPcSrc);
            testErrors++;
        end
        assert (pcTarget === expPcTarget) else begin
            $display("FAIL %0t: pcTarget %h, expected %h", $time, pcTarget, expPcTarget);
            testErrors++;
        end
        assert (mem === modelMem) else begin
            $display("FAIL %0t: mem %h, expected %h", $time, mem, modelMem);
            testErrors++;
        end
    endtask

    task driveCycle(input decodeBundle d, input wbBundle w, input logic idleCheck);
        decode = d;
        wb     = w;
        #1;
        evalModel(w);
        checkOutputs();
        if (idleCheck) begin
            assert (!mem.regWrite && !mem.memWrite && !pcSrc) else begin
                $display("FAIL %0t: controls active with only bubbles driven", $time);
                testErrors++;
            end
        end
        advanceModel(d);
        @(negedge clk);
    endtask

    task reportTest(input string name);
        $display("%-10s %0d checks, %0d errors, %s", name, testChecks, testErrors,
                 (testErrors == 0) ? "ok" : "failed");
        totalChecks += testChecks;
        totalErrors += testErrors;
        testCount++;
        testChecks = 0;
        testErrors = 0;
    endtask

    task runFlush();
        decodeBundle victim;
        for (int i = 0; i < flushReps; i++) begin
            victim          = makeStore();
            victim.regWrite = 1'b1;             // Must never reach mem
            driveCycle(randFields(0, 0, 4), randWb(), 1'b0);
            driveCycle(makeJump(randRange(2) == 0), randWb(), 1'b0);
            driveCycle(victim, randWb(), 1'b0);
            driveCycle(randFields(0, 0, 4), randWb(), 1'b0);
            // Victim sits in EX/MEM now
            testChecks++;
            assert (!mem.regWrite && !mem.memWrite) else begin
                $display("FAIL %0t: instruction behind a jump reached mem with controls set",
                         $time);
                testErrors++;
            end
        end
        reportTest("flush");
    endtask

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        decode     = '0;
        wb         = '0;
        modelEx    = '0;
        modelMem   = '0;
        testChecks = 0;
        testErrors = 0;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        for (int i = 0; i < bubbleCount; i++) driveCycle(randFields(0, 0, 4), randWb(), 1'b1);
        reportTest("reset");
        for (int i = 0; i < aluCount; i++) driveCycle(makeAlu(16, 8, 8), randWb(), 1'b0);
        reportTest("alu");
        for (int i = 0; i < fwdCount; i++) driveCycle(makeAlu(0, 0, 4), randWb(), 1'b0);
        reportTest("forward");
        for (int i = 0; i < branchCount; i++) driveCycle(randMix(), randWb(), 1'b0);
        reportTest("branch");
        runFlush();
        for (int i = 0; i < storeCount; i++) begin
            driveCycle((randRange(2) == 0) ? makeStore() : makeAlu(0, 0, 4), randWb(), 1'b0);
        end
        for (int i = 0; i < drainCount; i++) driveCycle(randFields(0, 0, 4), randWb(), 1'b0);
        reportTest("store");
        $display("Total: %0d tests, %0d checks, %0d errors", testCount, totalChecks, totalErrors);
        if (totalErrors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+sim
verilog/rvPkg.sv
verilog/comparator.sv
verilog/alu.sv
verilog/forwardUnit.sv
verilog/idExReg.sv
verilog/execute.sv
verilog/executeStage.sv
sim/tbExecuteStage.sv

// ==== Makefile ====
TOP = tbExecuteStage

.PHONY: build run clean

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o simv

run: build
	@out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
